// ==== dram_pkg.sv ====
package dram_pkg;

  // geometry of the DDR2 part
  localparam int ROW_BITS  = 13;
  localparam int COL_BITS  = 10;
  localparam int BANK_BITS = 2;
  localparam int A10_BIT   = 10; // auto-precharge or all-banks select

  // timing in dram_clk_0 cycles at 250 MHz
  localparam int RST_STRETCH    = 8;
  localparam int T_INIT_WAIT    = 50000; // 200 us power-up wait
  localparam int T_MRD          = 2;
  localparam int T_RCD          = 3;
  localparam int T_RAS_TAIL     = 4;
  localparam int T_RP           = 3;
  localparam int T_RFC          = 26;
  localparam int T_REFI         = 1950; // 7.8 us refresh interval
  localparam int INIT_CMD_COUNT = 8;

  localparam int INIT_WAIT_W = $clog2(T_INIT_WAIT + 1);
  localparam int INIT_STEP_W = $clog2(INIT_CMD_COUNT + 1);
  localparam int REFI_W      = $clog2(T_REFI);
  localparam int GAP_W       = $clog2(T_RFC);

  // counter load and compare values sized to their counters
  localparam logic [INIT_WAIT_W-1:0] WAIT_POWERUP   = INIT_WAIT_W'(T_INIT_WAIT);
  localparam logic [INIT_WAIT_W-1:0] WAIT_MRD       = INIT_WAIT_W'(T_MRD - 1);
  localparam logic [INIT_STEP_W-1:0] INIT_LAST_STEP = INIT_STEP_W'(INIT_CMD_COUNT);
  localparam logic [REFI_W-1:0]      REFI_LAST      = REFI_W'(T_REFI - 1);
  localparam logic [GAP_W-1:0]       GAP_RCD        = GAP_W'(T_RCD - 1);
  localparam logic [GAP_W-1:0]       GAP_RAS        = GAP_W'(T_RAS_TAIL - 1);
  localparam logic [GAP_W-1:0]       GAP_RP         = GAP_W'(T_RP - 1);
  localparam logic [GAP_W-1:0]       GAP_RFC        = GAP_W'(T_RFC - 1);

  // mode register contents
  localparam logic [2:0] BURST_LEN_CODE = 3'd2; // burst length 4
  localparam logic [2:0] CAS_LAT        = 3'd4;
  localparam logic [2:0] WRITE_REC_CODE = 3'd2; // write recovery of 3 cycles

  // scheduler states
  localparam logic [2:0] ST_IDLE   = 3'd0;
  localparam logic [2:0] ST_ACT    = 3'd1;
  localparam logic [2:0] ST_ACCESS = 3'd2;
  localparam logic [2:0] ST_PRE    = 3'd3;
  localparam logic [2:0] ST_REF    = 3'd4;

  // value is the {ras_n, cas_n, we_n} pattern
  typedef enum logic [2:0] {
    CMD_MRS = 3'b000,
    CMD_REF = 3'b001,
    CMD_PRE = 3'b010,
    CMD_ACT = 3'b011,
    CMD_WR  = 3'b100,
    CMD_RD  = 3'b101,
    CMD_NOP = 3'b111
  } dram_cmd_e;

  typedef union packed {
    logic [ROW_BITS-1:0] row; // row address, or column in the low bits
    struct packed {
      logic       power_down;     // A12
      logic [2:0] write_recovery; // A11..A9
      logic       dll_reset;      // A8
      logic       test_mode;      // A7
      logic [2:0] cas_latency;    // A6..A4
      logic       burst_type;     // A3
      logic [2:0] burst_length;   // A2..A0
    } mode;
  } dram_addr_u;

endpackage

// ==== dram_rst_gen.sv ====
`timescale 1ns/1ps

module dram_rst_gen (
  input  logic dram_clk_0,
  input  logic reset_int,
  input  logic usr_rst,
  input  logic pll_locked,
  output logic dram_rst
);

  logic [dram_pkg::RST_STRETCH-1:0] rst_sr;
  logic                             rst_src;

  assign rst_src  = reset_int | usr_rst | ~pll_locked; // any source restarts the stretch
  assign dram_rst = rst_sr[dram_pkg::RST_STRETCH-1];

  // all ones while a source is active, then zeros walk up to the top bit
  always_ff @(posedge dram_clk_0) begin
    if (rst_src) begin
      rst_sr <= '1;
    end else begin
      rst_sr <= {rst_sr[dram_pkg::RST_STRETCH-2:0], 1'b0};
    end
  end

endmodule

// ==== dram_init_seq.sv ====
`timescale 1ns/1ps

module dram_init_seq (
  input  logic                             dram_clk_0,
  input  logic                             dram_rst,
  output dram_pkg::dram_cmd_e              init_cmd,
  output logic [dram_pkg::BANK_BITS-1:0]   init_ba,
  output dram_pkg::dram_addr_u             init_addr,
  output logic                             init_done
);

  logic [dram_pkg::INIT_WAIT_W-1:0] wait_cnt;
  logic [dram_pkg::INIT_STEP_W-1:0] step;
  logic                             fire;

  assign fire = (wait_cnt == '0) && (step < dram_pkg::INIT_LAST_STEP);

  always_ff @(posedge dram_clk_0) begin
    if (dram_rst) begin
      wait_cnt  <= dram_pkg::WAIT_POWERUP; // 200 us before the first command
      step      <= '0;
      init_done <= 1'b0;
    end else begin
      if (fire) begin
        step     <= step + 1'b1;
        wait_cnt <= dram_pkg::WAIT_MRD;
      end else if (wait_cnt != '0) begin
        wait_cnt <= wait_cnt - 1'b1;
      end
      if ((step == dram_pkg::INIT_LAST_STEP) && (wait_cnt == 1)) begin
        init_done <= 1'b1; // tMRD after the final MRS
      end
    end
  end

  // power-up list, one entry per step
  always_comb begin
    init_cmd  = dram_pkg::CMD_NOP;
    init_ba   = '0;
    init_addr = '0;
    if (fire) begin
      case (step)
        4'd0, 4'd5: begin
          init_cmd                         = dram_pkg::CMD_PRE;
          init_addr.row[dram_pkg::A10_BIT] = 1'b1; // precharge all banks
        end
        4'd1: begin
          init_cmd = dram_pkg::CMD_MRS;
          init_ba  = 2'd2; // EMR2
        end
        4'd2: begin
          init_cmd = dram_pkg::CMD_MRS;
          init_ba  = 2'd3; // EMR3
        end
        4'd3: begin
          init_cmd = dram_pkg::CMD_MRS; // EMR1 with DLL enabled
          init_ba  = 2'd1;
        end
        4'd4, 4'd7: begin
          init_cmd                      = dram_pkg::CMD_MRS;
          init_addr.mode.write_recovery = dram_pkg::WRITE_REC_CODE;
          init_addr.mode.dll_reset      = (step == 4'd4); // only the first MR write resets the DLL
          init_addr.mode.cas_latency    = dram_pkg::CAS_LAT;
          init_addr.mode.burst_length   = dram_pkg::BURST_LEN_CODE;
        end
        4'd6: begin
          init_cmd = dram_pkg::CMD_REF;
        end
        default: begin
          init_cmd = dram_pkg::CMD_NOP;
        end
      endcase
    end
  end

endmodule

// ==== dram_refresh_timer.sv ====
`timescale 1ns/1ps

module dram_refresh_timer (
  input  logic dram_clk_0,
  input  logic dram_rst,
  input  logic init_done,
  input  logic ref_ack,
  output logic ref_req
);

  logic [dram_pkg::REFI_W-1:0] refi_cnt;
  logic                        refi_tc;

  assign refi_tc = (refi_cnt == dram_pkg::REFI_LAST);

  always_ff @(posedge dram_clk_0) begin
    if (dram_rst) begin
      refi_cnt <= '0;
      ref_req  <= 1'b0;
    end else begin
      if (!init_done) begin
        refi_cnt <= '0; // interval starts when init completes
      end else if (refi_tc) begin
        refi_cnt <= '0;
      end else begin
        refi_cnt <= refi_cnt + 1'b1;
      end

      // a single request bit, so a late refresh is never owed twice
      if (ref_ack) begin
        ref_req <= 1'b0;
      end else if (init_done && refi_tc) begin
        ref_req <= 1'b1;
      end
    end
  end

endmodule

// ==== dram_cmd_sched.sv ====
`timescale 1ns/1ps

module dram_cmd_sched (
  input  logic                           dram_clk_0,
  input  logic                           dram_rst,
  input  logic                           init_done,
  input  dram_pkg::dram_cmd_e            init_cmd,
  input  logic [dram_pkg::BANK_BITS-1:0] init_ba,
  input  dram_pkg::dram_addr_u           init_addr,
  input  logic                           ref_req,
  output logic                           ref_ack,
  input  logic                           usr_rd_req,
  input  logic                           usr_wr_req,
  input  logic [dram_pkg::BANK_BITS-1:0] usr_bank,
  input  logic [dram_pkg::ROW_BITS-1:0]  usr_row,
  input  logic [dram_pkg::COL_BITS-1:0]  usr_col,
  output logic                           usr_ready,
  output logic                           ras_n,
  output logic                           cas_n,
  output logic                           we_n,
  output logic [dram_pkg::BANK_BITS-1:0] ba,
  output dram_pkg::dram_addr_u           addr
);

  logic [2:0]                     state;
  logic [dram_pkg::GAP_W-1:0]     gap_cnt;
  logic                           rdy_q;
  logic                           accept;
  logic [dram_pkg::BANK_BITS-1:0] lat_bank;
  logic [dram_pkg::COL_BITS-1:0]  lat_col;
  logic                           lat_wr;
  dram_pkg::dram_cmd_e            sched_cmd;
  logic [dram_pkg::BANK_BITS-1:0] sched_ba;
  dram_pkg::dram_addr_u           sched_addr;
  dram_pkg::dram_cmd_e            pin_cmd;

  assign usr_ready = rdy_q & ~ref_req & ~dram_rst; // a pending refresh wins over user traffic
  assign accept    = usr_ready & (usr_rd_req | usr_wr_req);

  always_ff @(posedge dram_clk_0) begin
    if (dram_rst) begin
      state   <= dram_pkg::ST_IDLE;
      gap_cnt <= '0;
      rdy_q   <= 1'b0;
      ref_ack <= 1'b0;
    end else begin
      ref_ack <= 1'b0;
      if (gap_cnt != '0) begin
        gap_cnt <= gap_cnt - 1'b1;
      end
      case (state)
        dram_pkg::ST_IDLE: begin
          rdy_q <= init_done;
          if (ref_req) begin
            state   <= dram_pkg::ST_REF;
            gap_cnt <= dram_pkg::GAP_RFC;
            rdy_q   <= 1'b0;
            ref_ack <= 1'b1; // high in the same cycle REFRESH is on the pins
          end else if (accept) begin
            state   <= dram_pkg::ST_ACT;
            gap_cnt <= dram_pkg::GAP_RCD;
            rdy_q   <= 1'b0;
          end
        end
        dram_pkg::ST_ACT: begin
          if (gap_cnt == '0) begin
            state   <= dram_pkg::ST_ACCESS;
            gap_cnt <= dram_pkg::GAP_RAS;
          end
        end
        dram_pkg::ST_ACCESS: begin
          if (gap_cnt == '0) begin
            state   <= dram_pkg::ST_PRE;
            gap_cnt <= dram_pkg::GAP_RP;
          end
        end
        dram_pkg::ST_PRE, dram_pkg::ST_REF: begin
          if (gap_cnt == '0) begin
            state <= dram_pkg::ST_IDLE;
            rdy_q <= 1'b1;
          end
        end
        default: begin
          state <= dram_pkg::ST_IDLE;
        end
      endcase
    end
  end

  // request fields held for the column and precharge commands
  always_ff @(posedge dram_clk_0) begin
    if (accept) begin
      lat_bank <= usr_bank;
      lat_col  <= usr_col;
      lat_wr   <= usr_wr_req;
    end
  end

  always_comb begin
    sched_cmd  = dram_pkg::CMD_NOP;
    sched_ba   = lat_bank;
    sched_addr = '0;
    case (state)
      dram_pkg::ST_IDLE: begin
        if (ref_req) begin
          sched_cmd = dram_pkg::CMD_REF;
        end else if (accept) begin
          sched_cmd      = dram_pkg::CMD_ACT;
          sched_ba       = usr_bank;
          sched_addr.row = usr_row;
        end
      end
      dram_pkg::ST_ACT: begin
        if (gap_cnt == '0) begin
          sched_cmd      = lat_wr ? dram_pkg::CMD_WR : dram_pkg::CMD_RD;
          sched_addr.row = {{(dram_pkg::ROW_BITS - dram_pkg::COL_BITS){1'b0}}, lat_col}; // A10 low
        end
      end
      dram_pkg::ST_ACCESS: begin
        if (gap_cnt == '0) begin
          sched_cmd = dram_pkg::CMD_PRE; // single bank since A10 stays low
        end
      end
      default: begin
        sched_cmd = dram_pkg::CMD_NOP;
      end
    endcase
  end

  assign pin_cmd = init_done ? sched_cmd : init_cmd;

  always_ff @(posedge dram_clk_0) begin
    if (dram_rst) begin
      {ras_n, cas_n, we_n} <= dram_pkg::CMD_NOP;
      ba                   <= '0;
      addr                 <= '0;
    end else begin
      {ras_n, cas_n, we_n} <= pin_cmd; // enum value is the pin pattern
      ba                   <= init_done ? sched_ba : init_ba;
      addr                 <= init_done ? sched_addr : init_addr;
    end
  end

endmodule

// ==== dram_ctrl_top.sv ====
`timescale 1ns/1ps

module dram_ctrl_top (
  input  logic                           dram_clk_0,
  input  logic                           reset_int,
  input  logic                           pll_locked,
  input  logic                           usr_rst,
  input  logic                           usr_rd_req,
  input  logic                           usr_wr_req,
  input  logic [dram_pkg::BANK_BITS-1:0] usr_bank,
  input  logic [dram_pkg::ROW_BITS-1:0]  usr_row,
  input  logic [dram_pkg::COL_BITS-1:0]  usr_col,
  output logic                           dram_rst,
  output logic                           init_done,
  output logic                           usr_ready,
  output logic                           ras_n,
  output logic                           cas_n,
  output logic                           we_n,
  output logic [dram_pkg::BANK_BITS-1:0] ba,
  output dram_pkg::dram_addr_u           addr
);

  dram_pkg::dram_cmd_e            init_cmd;
  logic [dram_pkg::BANK_BITS-1:0] init_ba;
  dram_pkg::dram_addr_u           init_addr;
  logic                           ref_req;
  logic                           ref_ack;

  dram_rst_gen u_rst_gen (
    .dram_clk_0 (dram_clk_0),
    .reset_int  (reset_int),
    .usr_rst    (usr_rst),
    .pll_locked (pll_locked),
    .dram_rst   (dram_rst)
  );

  dram_init_seq u_init_seq (
    .dram_clk_0 (dram_clk_0),
    .dram_rst   (dram_rst),
    .init_cmd   (init_cmd),
    .init_ba    (init_ba),
    .init_addr  (init_addr),
    .init_done  (init_done)
  );

  dram_refresh_timer u_refresh_timer (
    .dram_clk_0 (dram_clk_0),
    .dram_rst   (dram_rst),
    .init_done  (init_done),
    .ref_ack    (ref_ack),
    .ref_req    (ref_req)
  );

  dram_cmd_sched u_cmd_sched (
    .dram_clk_0 (dram_clk_0),
    .dram_rst   (dram_rst),
    .init_done  (init_done),
    .init_cmd   (init_cmd),
    .init_ba    (init_ba),
    .init_addr  (init_addr),
    .ref_req    (ref_req),
    .ref_ack    (ref_ack),
    .usr_rd_req (usr_rd_req),
    .usr_wr_req (usr_wr_req),
    .usr_bank   (usr_bank),
    .usr_row    (usr_row),
    .usr_col    (usr_col),
    .usr_ready  (usr_ready),
    .ras_n      (ras_n),
    .cas_n      (cas_n),
    .we_n       (we_n),
    .ba         (ba),
    .addr       (addr)
  );

endmodule

// ==== dram_assertions.sv ====
`timescale 1ns/1ps

module dram_assertions (
  input logic                           dram_clk_0,
  input logic                           reset_int,
  input logic                           usr_rst,
  input logic                           pll_locked,
  input logic                           dram_rst,
  input logic                           init_done,
  input logic                           usr_ready,
  input logic                           usr_rd_req,
  input logic                           usr_wr_req,
  input logic                           ref_req,
  input logic [dram_pkg::BANK_BITS-1:0] usr_bank,
  input logic [dram_pkg::ROW_BITS-1:0]  usr_row,
  input logic [dram_pkg::COL_BITS-1:0]  usr_col,
  input logic                           ras_n,
  input logic                           cas_n,
  input logic                           we_n,
  input logic [dram_pkg::BANK_BITS-1:0] ba,
  input dram_pkg::dram_addr_u           addr
);

  localparam int RD_AT      = 1 + dram_pkg::T_RCD;
  localparam int PRE_AT     = RD_AT + dram_pkg::T_RAS_TAIL;
  localparam int ACC_LAST   = PRE_AT + dram_pkg::T_RP;
  localparam int REF_SLACK  = ACC_LAST + 4;

  dram_pkg::dram_cmd_e            cmd;
  logic                           src;
  logic                           accept;
  logic                           init_phase;
  logic                           seen_src = 1'b0;
  logic                           armed = 1'b0;
  logic                           rst_q = 1'b0;
  logic                           done_q = 1'b0;
  int                             quiet = 0;
  int                             step = 0;
  int                             since_cmd = 0;
  int                             acc_t = 0;
  int                             ref_gap = 0;
  int                             rfc = 0;
  logic [dram_pkg::BANK_BITS-1:0] lat_bank;
  logic [dram_pkg::ROW_BITS-1:0]  lat_row;
  logic [dram_pkg::COL_BITS-1:0]  lat_col;
  logic                           lat_wr;
  logic                           f_rst = 1'b0;
  logic                           f_init = 1'b0;
  logic                           f_acc = 1'b0;
  logic                           f_ref = 1'b0;
  logic                           fail_any;

  assign cmd        = dram_pkg::dram_cmd_e'({ras_n, cas_n, we_n});
  assign src        = reset_int | usr_rst | ~pll_locked;
  assign accept     = usr_ready & (usr_rd_req | usr_wr_req);
  assign init_phase = armed && !rst_q && !done_q;
  assign fail_any   = f_rst | f_init | f_acc | f_ref;

  function automatic dram_pkg::dram_cmd_e exp_init_cmd(input int s);
    case (s)
      0, 5:    return dram_pkg::CMD_PRE;
      6:       return dram_pkg::CMD_REF;
      default: return dram_pkg::CMD_MRS;
    endcase
  endfunction

  function automatic logic [dram_pkg::BANK_BITS-1:0] exp_init_ba(input int s);
    case (s)
      1:       return 2'd2; // EMR2
      2:       return 2'd3;
      3:       return 2'd1;
      default: return 2'd0;
    endcase
  endfunction

  function automatic dram_pkg::dram_cmd_e exp_acc_cmd(input int t, input logic wr);
    if (t == 1) return dram_pkg::CMD_ACT;
    if (t == RD_AT) return wr ? dram_pkg::CMD_WR : dram_pkg::CMD_RD;
    if (t == PRE_AT) return dram_pkg::CMD_PRE;
    return dram_pkg::CMD_NOP;
  endfunction

  // precharge only needs A10 low, the other address bits are free
  function automatic logic [dram_pkg::ROW_BITS-1:0] exp_acc_row(
    input int                            t,
    input logic [dram_pkg::ROW_BITS-1:0] row_q,
    input logic [dram_pkg::COL_BITS-1:0] col_q,
    input logic [dram_pkg::ROW_BITS-1:0] cur
  );
    logic [dram_pkg::ROW_BITS-1:0] pre_row;
    pre_row                   = cur;
    pre_row[dram_pkg::A10_BIT] = 1'b0;
    if (t == 1) return row_q;
    if (t == RD_AT) return {3'b000, col_q};
    return pre_row;
  endfunction

  always_ff @(posedge dram_clk_0) begin
    rst_q  <= dram_rst;
    done_q <= init_done;
    armed  <= armed | rst_q;
    if (src) begin
      seen_src <= 1'b1;
      quiet    <= 0;
    end else if (quiet < 100) begin
      quiet <= quiet + 1;
    end
    if (cmd != dram_pkg::CMD_NOP) begin
      since_cmd <= 1;
    end else if (since_cmd < 1000) begin
      since_cmd <= since_cmd + 1;
    end
    if (dram_rst) begin
      step  <= 0;
      acc_t <= 0;
      rfc   <= 0;
    end else begin
      if (init_phase && cmd != dram_pkg::CMD_NOP) step <= step + 1;
      if (accept) begin
        acc_t    <= 1; // ACT expected on the next sample
        lat_bank <= usr_bank;
        lat_row  <= usr_row;
        lat_col  <= usr_col;
        lat_wr   <= usr_wr_req;
      end else if (acc_t != 0 && acc_t < ACC_LAST) begin
        acc_t <= acc_t + 1;
      end else begin
        acc_t <= 0;
      end
      if (done_q && cmd == dram_pkg::CMD_REF) begin
        rfc <= dram_pkg::T_RFC;
      end else if (rfc != 0) begin
        rfc <= rfc - 1;
      end
    end
    if (!done_q || cmd == dram_pkg::CMD_REF) ref_gap <= 0;
    else ref_gap <= ref_gap + 1;
  end

  a_rst_stretch: assert property (@(posedge dram_clk_0)
    seen_src |-> dram_rst == (quiet < dram_pkg::RST_STRETCH))
    else begin
      f_rst = 1'b1;
      $error("Error: dram_rst %h expected %h", dram_rst, quiet < dram_pkg::RST_STRETCH);
    end

  a_rst_nop: assert property (@(posedge dram_clk_0) rst_q |-> cmd == dram_pkg::CMD_NOP)
    else begin
      f_rst = 1'b1;
      $error("Error: cmd %h expected %h during reset", cmd, dram_pkg::CMD_NOP);
    end

  // PRE-all must carry A10, every other entry just matches the list
  a_init_cmd: assert property (@(posedge dram_clk_0)
    (init_phase && cmd != dram_pkg::CMD_NOP) |->
      (step < dram_pkg::INIT_CMD_COUNT && cmd == exp_init_cmd(step) && ba == exp_init_ba(step)
       && (cmd != dram_pkg::CMD_PRE || addr.row[dram_pkg::A10_BIT])))
    else begin
      f_init = 1'b1;
      $error("Error: init cmd %h ba %h expected %h %h", cmd, ba, exp_init_cmd(step),
             exp_init_ba(step));
    end

  a_init_gap: assert property (@(posedge dram_clk_0)
    (init_phase && cmd != dram_pkg::CMD_NOP && step != 0) |-> since_cmd == dram_pkg::T_MRD)
    else begin
      f_init = 1'b1;
      $error("Error: init gap %h expected %h", since_cmd, dram_pkg::T_MRD);
    end

  a_init_mode: assert property (@(posedge dram_clk_0)
    (init_phase && cmd == dram_pkg::CMD_MRS && ba == '0) |->
      (addr.mode.burst_length == dram_pkg::BURST_LEN_CODE
       && addr.mode.cas_latency == dram_pkg::CAS_LAT))
    else begin
      f_init = 1'b1;
      $error("Error: burst_length %h cas_latency %h expected %h %h", addr.mode.burst_length,
             addr.mode.cas_latency, dram_pkg::BURST_LEN_CODE, dram_pkg::CAS_LAT);
    end

  a_init_len: assert property (@(posedge dram_clk_0)
    (armed && !rst_q && init_done && !done_q) |-> step == dram_pkg::INIT_CMD_COUNT)
    else begin
      f_init = 1'b1;
      $error("Error: init step %h expected %h", step, dram_pkg::INIT_CMD_COUNT);
    end

  a_acc_cmd: assert property (@(posedge dram_clk_0)
    (acc_t != 0) |-> cmd == exp_acc_cmd(acc_t, lat_wr))
    else begin
      f_acc = 1'b1;
      $error("Error: cmd %h expected %h", cmd, exp_acc_cmd(acc_t, lat_wr));
    end

  a_acc_addr: assert property (@(posedge dram_clk_0)
    (acc_t != 0 && cmd != dram_pkg::CMD_NOP) |->
      (ba == lat_bank && addr.row == exp_acc_row(acc_t, lat_row, lat_col, addr.row)))
    else begin
      f_acc = 1'b1;
      $error("Error: ba %h addr %h expected %h %h", ba, addr, lat_bank,
             exp_acc_row(acc_t, lat_row, lat_col, addr.row));
    end

  a_acc_ready: assert property (@(posedge dram_clk_0)
    (acc_t != 0) |-> usr_ready == (acc_t == ACC_LAST && !ref_req))
    else begin
      f_acc = 1'b1;
      $error("Error: usr_ready %h expected %h", usr_ready, acc_t == ACC_LAST && !ref_req);
    end

  // an ignored strobe leaves acc_t at zero, so no access command may show
  a_no_stray: assert property (@(posedge dram_clk_0)
    (done_q && acc_t == 0) |->
      !(cmd == dram_pkg::CMD_ACT || cmd == dram_pkg::CMD_RD || cmd == dram_pkg::CMD_WR))
    else begin
      f_acc = 1'b1;
      $error("Error: cmd %h issued without an accepted request", cmd);
    end

  a_ref_gap: assert property (@(posedge dram_clk_0)
    done_q |-> ref_gap <= dram_pkg::T_REFI + REF_SLACK)
    else begin
      f_ref = 1'b1;
      $error("refresh interval exceeded");
    end

  a_rfc_nop: assert property (@(posedge dram_clk_0) (rfc != 0) |-> cmd == dram_pkg::CMD_NOP)
    else begin
      f_ref = 1'b1;
      $error("Error: cmd %h expected %h after REFRESH", cmd, dram_pkg::CMD_NOP);
    end

endmodule

bind dram_ctrl_top dram_assertions u_assert (
  .dram_clk_0 (dram_clk_0),
  .reset_int  (reset_int),
  .usr_rst    (usr_rst),
  .pll_locked (pll_locked),
  .dram_rst   (dram_rst),
  .init_done  (init_done),
  .usr_ready  (usr_ready),
  .usr_rd_req (usr_rd_req),
  .usr_wr_req (usr_wr_req),
  .ref_req    (ref_req),
  .usr_bank   (usr_bank),
  .usr_row    (usr_row),
  .usr_col    (usr_col),
  .ras_n      (ras_n),
  .cas_n      (cas_n),
  .we_n       (we_n),
  .ba         (ba),
  .addr       (addr)
);

// ==== dram_tb.sv ====
`timescale 1ns/1ps

module dram_tb;

  logic                           dram_clk_0 = 1'b0;
  logic                           reset_int;
  logic                           pll_locked;
  logic                           usr_rst;
  logic                           usr_rd_req;
  logic                           usr_wr_req;
  logic [dram_pkg::BANK_BITS-1:0] usr_bank;
  logic [dram_pkg::ROW_BITS-1:0]  usr_row;
  logic [dram_pkg::COL_BITS-1:0]  usr_col;
  logic                           dram_rst;
  logic                           init_done;
  logic                           usr_ready;
  logic                           ras_n;
  logic                           cas_n;
  logic                           we_n;
  logic [dram_pkg::BANK_BITS-1:0] ba;
  dram_pkg::dram_addr_u           addr;
  int                             seed;
  int                             rnd;
  int                             cyc = 0;
  int                             start;
  int                             n;

  always #2 dram_clk_0 = ~dram_clk_0;

  always @(posedge dram_clk_0) cyc <= cyc + 1;

  dram_ctrl_top DUT (.*);

  task automatic next_cycle();
    @(posedge dram_clk_0);
    #0.5;
  endtask

  task automatic abort(input string msg);
    $display("CHECKS FAILED");
    $fatal(1, "%s", msg);
  endtask

  task automatic wait_init();
    int t;
    t = 0;
    while (!init_done) begin
      if (t > dram_pkg::T_INIT_WAIT + 200) abort("init_done did not rise after reset");
      next_cycle();
      t++;
    end
  endtask

  task automatic wait_ready();
    int t;
    t = 0;
    while (!usr_ready) begin
      if (t > 100) abort("usr_ready stayed low too long");
      next_cycle();
      t++;
    end
  endtask

  // one request, optionally followed by a strobe that must be ignored
  task automatic send_req(input logic stray);
    wait_ready();
    rnd        = $random(seed);
    usr_bank   = rnd[1:0];
    usr_row    = rnd[14:2];
    usr_col    = rnd[24:15];
    usr_wr_req = rnd[31];
    usr_rd_req = !rnd[31];
    next_cycle();
    usr_wr_req = 1'b0;
    usr_rd_req = 1'b0;
    if (stray) begin
      usr_rd_req = 1'b1;
      usr_row    = ~usr_row;
      next_cycle();
      usr_rd_req = 1'b0;
    end
    repeat (rnd[29:25]) next_cycle();
  endtask

  always @(negedge dram_clk_0) begin
    if (DUT.u_assert.fail_any) abort("an assertion failed");
  end

  initial begin
    seed       = 32'h02c72053;
    reset_int  = 1'b1;
    pll_locked = 1'b0;
    usr_rst    = 1'b0;
    usr_rd_req = 1'b0;
    usr_wr_req = 1'b0;
    usr_bank   = '0;
    usr_row    = '0;
    usr_col    = '0;
    repeat (16) next_cycle();
    reset_int = 1'b0;
    repeat (5) next_cycle();
    pll_locked = 1'b1;
    wait_init();
    start = cyc;
    n = 0;
    while (cyc - start < 2 * dram_pkg::T_REFI + 300) begin
      send_req(n % 5 == 2);
      n++;
    end
    wait_ready();
    usr_rst = 1'b1; // second reset through the user source
    repeat (3) next_cycle();
    usr_rst = 1'b0;
    wait_init();
    for (n = 0; n < 20; n++) begin
      send_req(n % 4 == 1);
    end
    repeat (40) next_cycle();
    if (DUT.u_assert.fail_any) begin
      $display("CHECKS FAILED");
      $fatal(1, "an assertion failed");
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

// ==== filelist.f ====
dram_pkg.sv
dram_rst_gen.sv
dram_init_seq.sv
dram_refresh_timer.sv
dram_cmd_sched.sv
dram_ctrl_top.sv
dram_assertions.sv
dram_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the DDR2 command controller testbench
rm -f sim.log
verilator --binary --timing --assert --top-module dram_tb -f filelist.f -o dram_sim \
  > sim.log 2>&1 \
  && ./obj_dir/dram_sim +verilator+error+limit+100 >> sim.log 2>&1
cat sim.log
grep -q "ALL CHECKS PASSED" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
